/* verilog.f */
+incdir+rtl
rtl/cart_pkg.sv
rtl/cart_stream_if.sv
rtl/flash_sig_scan.sv
rtl/title_quirk_match.sv
rtl/cart_profile.sv
rtl/cart_inspect_top.sv
test/cart_inspect_sva.sv
test/cart_inspect_checker.sv
test/cart_inspect_tb.sv

/* Makefile */
SIM  := obj_dir/Vcart_inspect_tb
SRCS := $(filter-out +incdir+%,$(shell cat verilog.f)) rtl/cart_config.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module cart_inspect_tb -f verilog.f

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/cart_inspect_tb.sv */
// Testbench top: clock, reset, pak image stimulus, reference profile, DUT and checker
`timescale 1ns/1ns

module cart_inspect_tb;

	localparam int clk_period = 8;
	localparam int max_bytes  = 'h180;  // Largest pak image streamed
	localparam int max_gap    = 3;      // Idle cycles after a beat, at most
	localparam int n_loads    = 12;     // Downloads in the whole run
	// Every beat with its longest gap, idle time per download, reset and margin
	localparam int cycle_limit = 16 + n_loads * ((max_bytes / 2) * (max_gap + 1) + 32) + 200;

	localparam logic [71:0] flash_sig = "FLASH1M_V";  // 128K flash library marker

	logic                     clk_sys;
	logic                     reset;
	logic                     dl_active;
	cart_pkg::dl_index_t      dl_index;
	logic                     dl_wr;
	cart_pkg::dl_addr_t       dl_addr;
	cart_pkg::dl_data_t       dl_data;
	logic                     profile_valid;
	logic                     cart_loaded;
	cart_pkg::cart_type_t     cart_type;
	logic                     force_turbo;
	logic                     flash_1m;
	logic                     sram_quirk;
	logic                     memory_remap;
	cart_pkg::pak_word_addr_t max_pak_addr;

	logic [31:0] exp_profile;     // Reference profile of the running download
	logic        expect_profile;  // Pak download, a pulse must follow
	logic        done;            // Asks the checker for its summary
	int          error_count;
	string       test_name;
	integer      seed;
	int          cycle_count = 0;
	logic [7:0]  img [max_bytes];  // Pak image, byte 0 first

	// ========================================
	// Reference model
	// ========================================

	// SRAM and remap quirk pair for a header title
	function automatic logic [1:0] quirk_pair(input logic [95:0] t);
		case (t)
			"ROCKY BOXING", "DRAGONBALL Z", {"IRIDIONII", 24'h000000}: return 2'b10;
			{"SUPER MARIO", 8'h00}, {"ZELDA 1", 40'h0000000000}, "STAR SOLDIER": return 2'b11;
			default: return 2'b00;
		endcase
	endfunction

	// Packed as loaded, type, turbo, flash, sram, remap, word address
	function automatic logic [31:0] ref_profile(input cart_pkg::dl_index_t idx, input int len);
		logic        found;
		logic [71:0] win;
		logic [95:0] title;
		logic [1:0]  quirks;
		found  = 1'b0;
		title  = '0;
		quirks = 2'b00;
		for (int k = 0; k + 9 <= len; k++) begin
			win = '0;
			for (int j = 0; j < 9; j++) begin
				win = {win[63:0], img[k + j]};
			end
			if (win == flash_sig) found = 1'b1;  // Any byte offset counts
		end
		if (len >= 'hAE) begin  // Header complete once 0xAC is written
			for (int j = 0; j < 12; j++) begin
				title = {title[87:0], img['hA0 + j]};
			end
			quirks = quirk_pair(title);
		end
		return {1'b1, idx[7:6], |idx[7:6], found, quirks, 25'((len - 2) >> 2)};
	endfunction

	// ========================================
	// Image building and streaming
	// ========================================

	task automatic fill_image(input int len);
		for (int a = 0; a < len; a++) begin
			img[a] = 8'($random(seed));
		end
	endtask

	task automatic place_sig(input int off);
		for (int j = 0; j < 9; j++) begin
			img[off + j] = flash_sig[71 - 8 * j -: 8];
		end
	endtask

	task automatic place_title(input logic [95:0] t);
		for (int j = 0; j < 12; j++) begin
			img['hA0 + j] = t[95 - 8 * j -: 8];  // First character at 0xA0
		end
	endtask

	task automatic run_download(input string name, input cart_pkg::dl_index_t idx, input int len);
		int gap;
		test_name      = name;
		expect_profile = (idx != 8'h00) && (idx != 8'hFF);  // BIOS and code publish nothing
		exp_profile    = ref_profile(idx, len);
		@(negedge clk_sys);
		dl_active = 1'b1;
		dl_index  = idx;
		for (int a = 0; a < len; a += 2) begin
			dl_wr   = 1'b1;
			dl_addr = cart_pkg::dl_addr_t'(a);
			dl_data = {img[a + 1], img[a]};  // Low byte is the earlier one
			@(negedge clk_sys);
			dl_wr = 1'b0;
			gap   = $unsigned($random(seed)) % (max_gap + 1);
			repeat (gap) @(negedge clk_sys);
		end
		dl_active = 1'b0;
		while (expect_profile && !profile_valid) @(negedge clk_sys);  // Timeout guards this
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic run_title(input string name, input cart_pkg::dl_index_t idx, input int len,
			input logic [95:0] t);
		fill_image(len);
		place_title(t);
		run_download(name, idx, len);
	endtask

	// ========================================
	// Clock, DUT, checker
	// ========================================

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	cart_inspect_top i_cart_inspect_top (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_active     (dl_active),
		.dl_index      (dl_index),
		.dl_wr         (dl_wr),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data),
		.profile_valid (profile_valid),
		.cart_loaded   (cart_loaded),
		.cart_type     (cart_type),
		.force_turbo   (force_turbo),
		.flash_1m      (flash_1m),
		.sram_quirk    (sram_quirk),
		.memory_remap  (memory_remap),
		.max_pak_addr  (max_pak_addr)
	);

	cart_inspect_checker i_cart_inspect_checker (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.profile_valid  (profile_valid),
		.cart_loaded    (cart_loaded),
		.cart_type      (cart_type),
		.force_turbo    (force_turbo),
		.flash_1m       (flash_1m),
		.sram_quirk     (sram_quirk),
		.memory_remap   (memory_remap),
		.max_pak_addr   (max_pak_addr),
		.exp_profile    (exp_profile),
		.expect_profile (expect_profile),
		.done           (done),
		.error_count    (error_count)
	);

	// Run limit from the download count and lengths
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles in %s, the profile never arrived",
				cycle_count, test_name);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		seed           = 84822;
		reset          = 1'b1;
		dl_active      = 1'b0;
		dl_index       = '0;
		dl_wr          = 1'b0;
		dl_addr        = '0;
		dl_data        = '0;
		exp_profile    = '0;
		expect_profile = 1'b0;
		done           = 1'b0;
		test_name      = "reset";
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		reset     = 1'b0;
		test_name = "reset_hold";  // Profile must stay zero
		repeat (8) @(negedge clk_sys);

		fill_image('h100);
		place_sig('h40);
		run_download("flash_even", 8'h01, 'h100);
		fill_image('h13A);
		place_sig('h67);
		run_download("flash_odd", 8'h41, 'h13A);
		fill_image('h0C0);
		run_download("flash_none", 8'h82, 'h0C0);  // Clears the earlier find

		run_title("title_rocky", 8'hC3, 'h180, "ROCKY BOXING");
		run_title("title_dbz", 8'h02, 'h0F0, "DRAGONBALL Z");
		run_title("title_iridion", 8'h45, 'h124, {"IRIDIONII", 24'h000000});
		run_title("title_mario", 8'h86, 'h15E, {"SUPER MARIO", 8'h00});
		run_title("title_zelda", 8'hC7, 'h0C8, {"ZELDA 1", 40'h0000000000});
		run_title("title_star", 8'h08, 'h17E, "STAR SOLDIER");
		run_title("title_unknown", 8'h49, 'h110, "PUZZLE QUEST");

		// Non-cart images carry a marker and a quirk title, nothing may change
		fill_image('h100);
		place_sig('h20);
		place_title("ROCKY BOXING");
		run_download("bios", 8'h00, 'h100);
		run_download("code", 8'hFF, 'h100);

		done = 1'b1;
		@(negedge clk_sys);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* test/cart_inspect_checker.sv */
// Profile checker: compares each published profile with the reference, watches the hold
`timescale 1ns/1ns

module cart_inspect_checker (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     profile_valid,
	input  logic                     cart_loaded,
	input  cart_pkg::cart_type_t     cart_type,
	input  logic                     force_turbo,
	input  logic                     flash_1m,
	input  logic                     sram_quirk,
	input  logic                     memory_remap,
	input  cart_pkg::pak_word_addr_t max_pak_addr,
	input  logic [31:0]              exp_profile,
	input  logic                     expect_profile,
	input  logic                     done,
	output int                       error_count
);

	int          errors = 0;
	int          check_count = 0;
	logic [31:0] act;   // Same packing as the reference
	logic [31:0] held;  // Profile on the previous falling edge

	assign act = {cart_loaded, cart_type, force_turbo, flash_1m, sram_quirk, memory_remap,
		max_pak_addr};
	assign error_count = errors;

	task automatic compare_field(input string field, input logic [24:0] exp_v,
			input logic [24:0] act_v);
		if (exp_v !== act_v) begin
			errors++;
			$display("ERR %s %s expected %0h actual %0h", cart_inspect_tb.test_name, field,
				exp_v, act_v);
		end
	endtask

	// Falling edge, outputs settled
	always @(negedge clk_sys) begin
		if (reset) begin
			held = '0;  // Reset profile is all zero
		end else begin
			if (profile_valid && !expect_profile) begin
				errors++;
				$display("%s: profile_valid pulsed on a BIOS or code download",
					cart_inspect_tb.test_name);
			end else if (profile_valid) begin
				check_count++;
				compare_field("cart_loaded", 25'(exp_profile[31]), 25'(act[31]));
				compare_field("cart_type", 25'(exp_profile[30:29]), 25'(act[30:29]));
				compare_field("force_turbo", 25'(exp_profile[28]), 25'(act[28]));
				compare_field("flash_1m", 25'(exp_profile[27]), 25'(act[27]));
				compare_field("sram_quirk", 25'(exp_profile[26]), 25'(act[26]));
				compare_field("memory_remap", 25'(exp_profile[25]), 25'(act[25]));
				compare_field("max_pak_addr", exp_profile[24:0], act[24:0]);
			end else if (act !== held) begin
				errors++;
				$display("%s: profile outputs changed without profile_valid",
					cart_inspect_tb.test_name);
			end
			held = act;
		end
	end

	always @(posedge done) begin
		$display("Checker summary: %0d profiles compared, %0d errors", check_count, errors);
	end

endmodule

/* test/cart_inspect_sva.sv */
// Profile output assertions, bound into the profile block
`timescale 1ns/1ns

module cart_inspect_sva (
	input logic                     clk_sys,
	input logic                     reset,
	input logic                     profile_valid,
	input logic                     cart_loaded,
	input cart_pkg::cart_type_t     cart_type,
	input logic                     force_turbo,
	input logic                     flash_1m,
	input logic                     sram_quirk,
	input logic                     memory_remap,
	input cart_pkg::pak_word_addr_t max_pak_addr
);

	logic [31:0] profile;  // All published fields

	assign profile = {cart_loaded, cart_type, force_turbo, flash_1m, sram_quirk, memory_remap,
		max_pak_addr};

	// ========================================
	// Profile rules
	// ========================================

	valid_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		profile_valid |=> !profile_valid)
		else $error("profile_valid stayed high for more than one cycle");

	turbo_from_type: assert property (@(posedge clk_sys) disable iff (reset)
		force_turbo == (|cart_type))
		else $error("force_turbo does not follow cart_type");

	// Fields move only on the publish edge
	hold_between: assert property (@(posedge clk_sys) disable iff (reset)
		!profile_valid |-> $stable(profile))
		else $error("profile changed without profile_valid");

endmodule

bind cart_profile cart_inspect_sva i_cart_inspect_sva (.*);

/* rtl/cart_inspect_top.sv */
// Cart inspection top: stream interface, profile block and the two header scanners
`timescale 1ns/1ns

module cart_inspect_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     dl_active,
	input  cart_pkg::dl_index_t      dl_index,
	input  logic                     dl_wr,
	input  cart_pkg::dl_addr_t       dl_addr,
	input  cart_pkg::dl_data_t       dl_data,
	output logic                     profile_valid,
	output logic                     cart_loaded,
	output cart_pkg::cart_type_t     cart_type,
	output logic                     force_turbo,
	output logic                     flash_1m,
	output logic                     sram_quirk,
	output logic                     memory_remap,
	output cart_pkg::pak_word_addr_t max_pak_addr
);

	logic flash_found;        // From the signature scanner
	logic title_sram_quirk;   // From the title lookup
	logic title_remap_quirk;

	cart_stream_if cart_stream ();  // Shared by both scanners

	// ========================================
	// Profile and input stage
	// ========================================

	cart_profile i_cart_profile (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.dl_active      (dl_active),
		.dl_index       (dl_index),
		.dl_wr          (dl_wr),
		.dl_addr        (dl_addr),
		.dl_data        (dl_data),
		.stream         (cart_stream),
		.flash_found    (flash_found),
		.sram_quirk_in  (title_sram_quirk),
		.remap_quirk_in (title_remap_quirk),
		.profile_valid  (profile_valid),
		.cart_loaded    (cart_loaded),
		.cart_type      (cart_type),
		.force_turbo    (force_turbo),
		.flash_1m       (flash_1m),
		.sram_quirk     (sram_quirk),
		.memory_remap   (memory_remap),
		.max_pak_addr   (max_pak_addr)
	);

	// Scanners side by side, same beats
	flash_sig_scan i_flash_sig_scan (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.stream      (cart_stream),
		.flash_found (flash_found)
	);

	title_quirk_match i_title_quirk_match (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.stream      (cart_stream),
		.sram_quirk  (title_sram_quirk),
		.remap_quirk (title_remap_quirk)
	);

endmodule

/* rtl/cart_profile.sv */
// Loader input registers, cart download decode, profile FSM and published profile
`timescale 1ns/1ns

module cart_profile (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     dl_active,
	input  cart_pkg::dl_index_t      dl_index,
	input  logic                     dl_wr,
	input  cart_pkg::dl_addr_t       dl_addr,
	input  cart_pkg::dl_data_t       dl_data,
	cart_stream_if.source            stream,
	input  logic                     flash_found,
	input  logic                     sram_quirk_in,
	input  logic                     remap_quirk_in,
	output logic                     profile_valid,
	output logic                     cart_loaded,
	output cart_pkg::cart_type_t     cart_type,
	output logic                     force_turbo,
	output logic                     flash_1m,
	output logic                     sram_quirk,
	output logic                     memory_remap,
	output cart_pkg::pak_word_addr_t max_pak_addr
);

	logic                     dl_active_q;
	logic                     dl_wr_q;
	cart_pkg::dl_index_t      dl_index_q;
	cart_pkg::dl_addr_t       dl_addr_q;
	cart_pkg::dl_data_t       dl_data_q;
	logic                     cart_dl;     // Registered download is a game pak
	logic                     dl_done;     // Cart stream just stopped
	cart_pkg::profile_state_t state;
	cart_pkg::dl_addr_t       last_addr;   // Last written byte address
	cart_pkg::cart_type_t     type_q;      // Index bits 7:6 of this download

	// ========================================
	// Input stage
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			dl_wr_q     <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			dl_wr_q     <= dl_wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		dl_index_q <= dl_index;
		dl_addr_q  <= dl_addr;
		dl_data_q  <= dl_data;
	end

	// Index 0 is BIOS, all ones is code, anything else a pak
	assign cart_dl = dl_active_q & (dl_index_q != '0) & (dl_index_q != '1);
	assign dl_done = (state == cart_pkg::loading) & ~cart_dl;

	assign stream.start = cart_dl & (state != cart_pkg::loading);  // Also right after publish
	assign stream.wr    = cart_dl & dl_wr_q;
	assign stream.addr  = dl_addr_q;
	assign stream.data  = dl_data_q;

	// ========================================
	// Profile FSM
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= cart_pkg::idle;
		end else begin
			case (state)
				cart_pkg::idle:    state <= stream.start ? cart_pkg::loading : cart_pkg::idle;
				cart_pkg::loading: state <= cart_dl ? cart_pkg::loading : cart_pkg::publish;
				cart_pkg::publish: state <= stream.start ? cart_pkg::loading : cart_pkg::idle;
				default:           state <= cart_pkg::idle;
			endcase
		end
	end

	assign profile_valid = (state == cart_pkg::publish);  // One cycle per cart download

	always_ff @(posedge clk_sys) begin
		if (stream.start) begin
			type_q    <= dl_index_q[7:6];
			last_addr <= '0;  // Empty download reports address 0
		end
		if (stream.wr) begin
			last_addr <= dl_addr_q;
		end
	end

	// Scanner flags settled one edge after the last beat
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_loaded  <= 1'b0;
			cart_type    <= '0;
			force_turbo  <= 1'b0;
			flash_1m     <= 1'b0;
			sram_quirk   <= 1'b0;
			memory_remap <= 1'b0;
			max_pak_addr <= '0;
		end else if (dl_done) begin
			cart_loaded  <= 1'b1;
			cart_type    <= type_q;
			force_turbo  <= |type_q;  // Non GBA cart types run at full speed
			flash_1m     <= flash_found;
			sram_quirk   <= sram_quirk_in;
			memory_remap <= remap_quirk_in;
			max_pak_addr <= cart_pkg::pak_word_addr_t'(last_addr >> 2);
		end
	end

endmodule

/* rtl/title_quirk_match.sv */
// ROM header title capture and lookup in the SRAM disable and memory remap quirk table
`timescale 1ns/1ns

`include "cart_config.svh"

module title_quirk_match (
	input  logic        clk_sys,
	input  logic        reset,
	cart_stream_if.scan stream,
	output logic        sram_quirk,
	output logic        remap_quirk
);

	localparam int title_n = `CART_TITLE_BYTES;
	localparam int quirk_n = 6;

	// ========================================
	// Quirk table
	// ========================================

	// Short titles are zero padded in the header
	localparam cart_pkg::title_t quirk_titles [quirk_n] = '{
		"ROCKY BOXING",                // Boxing title, SRAM only
		"DRAGONBALL Z",                // Legacy of Goku EU
		{"IRIDIONII", 24'h000000},     // Shooter, SRAM only
		{"SUPER MARIO", 8'h00},        // NES classic series
		{"ZELDA 1", 40'h0000000000},   // NES classic series
		"STAR SOLDIER"                 // Famicom mini series
	};

	// Bit i belongs to table entry i
	localparam logic [quirk_n-1:0] sram_tab  = 6'b111111;
	localparam logic [quirk_n-1:0] remap_tab = 6'b111000;  // NES ports also remap

	cart_pkg::title_t   title;      // Captured header title
	cart_pkg::dl_addr_t title_off;  // Beat address relative to the title start
	logic               title_end;  // First beat past the title
	logic               hit_sram;
	logic               hit_remap;

	assign title_off = stream.addr - cart_pkg::dl_addr_t'(`CART_TITLE_BASE);
	assign title_end = (stream.addr ==
		cart_pkg::dl_addr_t'(`CART_TITLE_BASE + `CART_TITLE_BYTES));

	// ========================================
	// Title capture
	// ========================================

	// Each beat fills two characters, low byte is the earlier one
	always_ff @(posedge clk_sys) begin
		if (stream.wr) begin
			for (int k = 0; k < title_n; k += 2) begin
				if (title_off == cart_pkg::dl_addr_t'(k)) begin
					title[(title_n - 2 - k) * 8 +: 16] <= {stream.data[7:0], stream.data[15:8]};
				end
			end
		end
	end

	// Full table compare on the captured title
	always_comb begin
		hit_sram  = 1'b0;
		hit_remap = 1'b0;
		for (int i = 0; i < quirk_n; i++) begin
			if (title == quirk_titles[i]) begin
				hit_sram  = hit_sram | sram_tab[i];
				hit_remap = hit_remap | remap_tab[i];
			end
		end
	end

	// ========================================
	// Result flags
	// ========================================

	// All twelve characters are in once the beat after the title arrives
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sram_quirk  <= 1'b0;
			remap_quirk <= 1'b0;
		end else if (stream.wr && title_end) begin
			sram_quirk  <= hit_sram;
			remap_quirk <= hit_remap;
		end else if (stream.start) begin
			sram_quirk  <= 1'b0;  // Unknown until the header is seen
			remap_quirk <= 1'b0;
		end
	end

endmodule

/* rtl/flash_sig_scan.sv */
// Flash 1M save chip signature scanner, matches at either byte alignment of a beat
`timescale 1ns/1ns

`include "cart_config.svh"

module flash_sig_scan (
	input  logic        clk_sys,
	input  logic        reset,
	cart_stream_if.scan stream,
	output logic        flash_found
);

	localparam int sig_w = `CART_SIG_BYTES * 8;
	localparam logic [sig_w-1:0] flash_sig = `CART_FLASH_SIG;

	logic [sig_w-9:0] hist;      // Previous image bytes, oldest at the top
	logic [sig_w-9:0] hist_cur;  // History this beat compares against
	logic [7:0]       byte_lo;   // Earlier byte of the beat
	logic [7:0]       byte_hi;   // Later byte of the beat
	logic             match_lo;
	logic             match_hi;

	assign byte_lo = stream.data[7:0];
	assign byte_hi = stream.data[15:8];

	// Fresh download starts from an empty history
	// Zero bytes never occur in the marker
	assign hist_cur = stream.start ? '0 : hist;

	// ========================================
	// Two windows per beat
	// ========================================

	// Marker ends on the low byte
	assign match_lo = ({hist_cur, byte_lo} == flash_sig);
	// Marker ends on the high byte
	assign match_hi = ({hist_cur[sig_w-17:0], byte_lo, byte_hi} == flash_sig);

	// Shift in both bytes in image order
	always_ff @(posedge clk_sys) begin
		if (stream.wr) begin
			hist <= {hist_cur[sig_w-25:0], byte_lo, byte_hi};
		end else if (stream.start) begin
			hist <= '0;
		end
	end

	// Sticky for the rest of the download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			flash_found <= 1'b0;
		end else if (stream.wr && (match_lo || match_hi)) begin
			flash_found <= 1'b1;
		end else if (stream.start) begin
			flash_found <= 1'b0;  // New pak, forget the old result
		end
	end

endmodule

/* rtl/cart_stream_if.sv */
// Registered cart download stream with source and scan modports
`timescale 1ns/1ns

interface cart_stream_if;

	logic                start;  // First cycle of a cart download
	logic                wr;     // Beat valid, no stall possible
	cart_pkg::dl_addr_t  addr;   // Byte address of the low byte
	cart_pkg::dl_data_t  data;   // Low byte is the earlier image byte

	// Profile block owns the stream
	modport source (
		output start,
		output wr,
		output addr,
		output data
	);

	// Scanners listen in parallel
	modport scan (
		input  start,
		input  wr,
		input  addr,
		input  data
	);

endinterface

/* rtl/cart_pkg.sv */
// Cart inspection types: stream vectors, pak word address, title and profile FSM states

`include "cart_config.svh"

package cart_pkg;

	// ========================================
	// Loader stream
	// ========================================

	typedef logic [`CART_ADDR_W-1:0] dl_addr_t;  // Byte address
	typedef logic [`CART_DATA_W-1:0] dl_data_t;  // Low byte comes first in the image
	typedef logic [7:0]              dl_index_t; // 0 is BIOS, all ones is code

	// ========================================
	// Profile fields
	// ========================================

	// 32-bit word address, byte address without bits 1:0
	typedef logic [`CART_ADDR_W-3:0] pak_word_addr_t;

	typedef logic [1:0] cart_type_t;  // Index bits 7:6

	// Header title in string order, first character in the top byte
	typedef logic [`CART_TITLE_BYTES*8-1:0] title_t;

	typedef enum logic [1:0] {
		idle,     // No cart download seen
		loading,  // Cart beats streaming
		publish   // Profile valid this cycle
	} profile_state_t;

endpackage

/* rtl/cart_config.svh */
// Cart stream widths, ROM header title placement and flash signature macros
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// ========================================
// Download stream
// ========================================

// Byte address of the loader stream
`define CART_ADDR_W 27
// One beat, two image bytes
`define CART_DATA_W 16

// ========================================
// ROM header
// ========================================

`define CART_TITLE_BASE 'h0A0   // Game title start in the pak header
`define CART_TITLE_BYTES 12     // Title length, zero padded when short

// ========================================
// Save chip detect
// ========================================

// Marker string left in the pak by the 128K flash library
`define CART_FLASH_SIG "FLASH1M_V"
`define CART_SIG_BYTES 9        // Length of the marker above

`endif
